//--- icache_maint.f
+incdir+verilog
+incdir+test
verilog/periph_bus_pkg.sv
verilog/icache_maint_pkg.sv
verilog/icache_maint_regs.sv
verilog/icache_maint_fsm.sv
verilog/periph_resp_stage.sv
verilog/icache_maint_top.sv
test/tb_icache_maint.sv

//--- Makefile
# Verilator build and run of the I-cache maintenance controller testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_icache_maint
FILELIST  := icache_maint.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(wildcard verilog/*.sv verilog/*.svh test/*.sv test/*.svh)
PASS_MSG  := Regression passed

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- test/tb_icache_maint_tasks.svh
/*
 * Testbench tasks of the I-cache maintenance controller
 * Mismatch reporting, bus read and write, per-test bookkeeping
 */

`ifndef TB_ICACHE_MAINT_TASKS_SVH
`define TB_ICACHE_MAINT_TASKS_SVH

task automatic report_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    errors++;
    $display("Mismatch at %0t: %s = %0h, expected %0h", $time, name, got, exp);
endtask

// One bus transaction, returns after its response
task automatic bus_access(input logic [`ICM_OFS_BITS-1:0] ofs, input logic read,
                          input logic [`ICM_DATA_W-1:0] data);
    periph_bus_pkg::periph_req_t r;
    r       = '0;
    r.req   = 1'b1;
    r.addr  = {{(`ICM_ADDR_W-`ICM_OFS_BITS){1'b0}}, ofs};
    r.wen   = read;
    r.wdata = data;
    r.be    = '1;
    r.id    = next_id;
    @(posedge clk);
    req     <= r;
    next_id <= next_id + 1'b1;
    @(negedge clk);
    while (!gnt)
        @(negedge clk);   // Held until granted
    @(posedge clk);
    req <= '0;
    @(negedge clk);
    while (!rsp.valid)
        @(negedge clk);
endtask

task automatic write_reg(input logic [`ICM_OFS_BITS-1:0] ofs,
                         input logic [`ICM_DATA_W-1:0] data);
    bus_access(ofs, 1'b0, data);
endtask

task automatic read_reg(input logic [`ICM_OFS_BITS-1:0] ofs);
    bus_access(ofs, 1'b1, '0);   // Read data checked by assertion
endtask

task automatic start_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
endtask

task automatic finish_test();
    if (errors == errors_at_start)
    begin
        tests_ok++;
        $display("[%0t] %s: ok", $time, cur_test);
    end
    else
    begin
        tests_bad++;
        $display("[%0t] %s: FAILED, %0d errors", $time, cur_test, errors - errors_at_start);
    end
endtask

`endif

//--- test/tb_icache_maint.sv
/*
 * Testbench of the I-cache maintenance controller
 * Clock, reset, bank models, reference model of the bus and
 * register rules, assertions, watchdog and test sequence
 */

`timescale 1ns/1ps

`include "icache_maint_defs.svh"

module tb_icache_maint;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_OPS      = 11;
    localparam int OP_CYCLES    = 24;   // Slowest bank answer plus bus overhead
    localparam int TIMEOUT_NS   = (RESET_CYCLES + NUM_OPS * OP_CYCLES) * CLK_PERIOD;

    localparam logic [2:0] OP_NONE      = 3'd0;
    localparam logic [2:0] OP_ENABLE    = 3'd1;
    localparam logic [2:0] OP_DISABLE   = 3'd2;
    localparam logic [2:0] OP_FLUSH     = 3'd3;
    localparam logic [2:0] OP_SEL_FLUSH = 3'd4;

    logic                         clk      = 1'b0;
    logic                         rst_n    = 1'b0;
    periph_bus_pkg::periph_req_t  req      = '0;
    icache_maint_pkg::bank_ack_t  bank_ack = {{`ICM_NB_BYPASS{1'b1}}, 2'b00};
    periph_bus_pkg::periph_rsp_t  rsp;
    icache_maint_pkg::bank_cmd_t  bank_cmd;
    logic                         gnt;

    integer                  seed = 32'h85e;
    logic [3:0]              byp_cnt [`ICM_NB_BYPASS];
    logic [3:0]              flush_cnt;
    logic [3:0]              sel_cnt;

    // Reference model state
    logic                    m_enable   = 1'b0;
    logic                    m_flush    = 1'b0;
    logic [`ICM_ADDR_W-1:0]  m_sel_addr = '0;
    logic                    pend       = 1'b0;   // Bank operation outstanding
    logic [2:0]              pend_kind  = OP_NONE;
    logic                    op_done;
    logic                    rsp_exp    = 1'b0;   // Response due this cycle
    logic                    exp_read   = 1'b0;
    logic [`ICM_ID_W-1:0]    exp_id     = '0;
    logic [`ICM_DATA_W-1:0]  exp_rdata  = '0;

    logic [`ICM_ID_W-1:0]    next_id = '0;
    logic [`ICM_DATA_W-1:0]  sel_addr;
    int                      errors = 0;
    int                      errors_at_start = 0;
    int                      tests_ok = 0;
    int                      tests_bad = 0;
    string                   cur_test;

    `include "tb_icache_maint_tasks.svh"

    icache_maint_top i_icache_maint_top (
        .clk_i      ( clk      ),
        .rst_ni     ( rst_n    ),
        .req_i      ( req      ),
        .gnt_o      ( gnt      ),
        .rsp_o      ( rsp      ),
        .bank_cmd_o ( bank_cmd ),
        .bank_ack_i ( bank_ack )
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [3:0] delay_draw();
        logic [31:0] r;
        r = $random(seed);
        return {1'b0, r[2:0]} + 4'd1;   // 1 to 8 cycles
    endfunction

    function automatic logic [`ICM_DATA_W-1:0] expected_read(
        input logic [`ICM_ADDR_W-1:0] addr);
        case (addr[`ICM_OFS_BITS-1:0])
            `ICM_OFS_ENABLE:    return {{(`ICM_DATA_W-1){1'b0}}, m_enable};
            `ICM_OFS_FLUSH:     return {{(`ICM_DATA_W-1){1'b0}}, m_flush};
            `ICM_OFS_SEL_FLUSH: return m_sel_addr;
            default:            return `ICM_UNMAPPED_RDATA;
        endcase
    endfunction

    always_comb
    begin
        case (pend_kind)
            OP_ENABLE:    op_done = ~|bank_ack.bypass_ack;
            OP_DISABLE:   op_done = &bank_ack.bypass_ack;
            OP_FLUSH:     op_done = bank_ack.flush_ack;
            OP_SEL_FLUSH: op_done = bank_ack.sel_flush_ack;
            default:      op_done = 1'b0;
        endcase
    end

    // Banks: each bypass line follows the request after its own delay
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            bank_ack  <= {{`ICM_NB_BYPASS{1'b1}}, 2'b00};
            flush_cnt <= 4'd1;
            sel_cnt   <= 4'd1;
            for (int i = 0; i < `ICM_NB_BYPASS; i++)
                byp_cnt[i] <= 4'd1;
        end
        else
        begin
            for (int i = 0; i < `ICM_NB_BYPASS; i++)
            begin
                if (bank_ack.bypass_ack[i] == bank_cmd.bypass_req)
                    byp_cnt[i] <= delay_draw();
                else if (byp_cnt[i] == 4'd0)
                    bank_ack.bypass_ack[i] <= bank_cmd.bypass_req;
                else
                    byp_cnt[i] <= byp_cnt[i] - 4'd1;
            end
            if (bank_ack.flush_ack)
                bank_ack.flush_ack <= 1'b0;   // One-cycle acknowledge
            else if (!bank_cmd.flush_req)
                flush_cnt <= delay_draw();
            else if (flush_cnt == 4'd0)
                bank_ack.flush_ack <= 1'b1;
            else
                flush_cnt <= flush_cnt - 4'd1;
            if (bank_ack.sel_flush_ack)
                bank_ack.sel_flush_ack <= 1'b0;
            else if (!bank_cmd.sel_flush_req)
                sel_cnt <= delay_draw();
            else if (sel_cnt == 4'd0)
                bank_ack.sel_flush_ack <= 1'b1;
            else
                sel_cnt <= sel_cnt - 4'd1;
        end
    end

    // Expected bus and register behavior
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            m_enable  <= 1'b0;
            m_flush   <= 1'b0;
            pend      <= 1'b0;
            pend_kind <= OP_NONE;
            rsp_exp   <= 1'b0;
        end
        else
        begin
            rsp_exp <= 1'b0;
            if (pend && op_done)
            begin
                pend      <= 1'b0;
                pend_kind <= OP_NONE;
                rsp_exp   <= 1'b1;
                if (pend_kind == OP_FLUSH)
                    m_flush <= 1'b0;
            end
            else if (req.req && !pend)   // Accepted this cycle
            begin
                exp_id   <= req.id;
                exp_read <= req.wen;
                if (req.wen)
                begin
                    rsp_exp   <= 1'b1;
                    exp_rdata <= expected_read(req.addr);
                end
                else
                begin
                    case (req.addr[`ICM_OFS_BITS-1:0])
                        `ICM_OFS_ENABLE:
                        begin
                            m_enable  <= req.wdata[0];
                            pend      <= 1'b1;
                            pend_kind <= req.wdata[0] ? OP_ENABLE : OP_DISABLE;
                        end
                        `ICM_OFS_FLUSH:
                        begin
                            m_flush   <= req.wdata[0];
                            pend      <= 1'b1;
                            pend_kind <= OP_FLUSH;
                        end
                        `ICM_OFS_SEL_FLUSH:
                        begin
                            m_sel_addr <= req.wdata;
                            pend       <= 1'b1;
                            pend_kind  <= OP_SEL_FLUSH;
                        end
                        default: rsp_exp <= 1'b1;   // Unmapped write
                    endcase
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) gnt == !pend)
    else report_mismatch("gnt_o", 32'($sampled(gnt)), 32'(!$sampled(pend)));

    assert property (@(posedge clk) disable iff (!rst_n) rsp.valid == rsp_exp)
    else report_mismatch("rsp_o.valid", 32'($sampled(rsp.valid)), 32'($sampled(rsp_exp)));

    assert property (@(posedge clk) disable iff (!rst_n) rsp.valid |-> rsp.id == exp_id)
    else report_mismatch("rsp_o.id", 32'($sampled(rsp.id)), 32'($sampled(exp_id)));

    // No error responses on this bus
    assert property (@(posedge clk) disable iff (!rst_n) rsp.valid |-> rsp.opc == 1'b0)
    else report_mismatch("rsp_o.opc", 32'($sampled(rsp.opc)), 32'd0);

    assert property (@(posedge clk) disable iff (!rst_n)
        rsp.valid && exp_read |-> rsp.rdata == exp_rdata)
    else report_mismatch("rsp_o.rdata", $sampled(rsp.rdata), $sampled(exp_rdata));

    assert property (@(posedge clk) disable iff (!rst_n) bank_cmd.bypass_req == !m_enable)
    else report_mismatch("bypass_req", 32'($sampled(bank_cmd.bypass_req)),
                         32'(!$sampled(m_enable)));

    assert property (@(posedge clk) disable iff (!rst_n) bank_cmd.flush_req == m_flush)
    else report_mismatch("flush_req", 32'($sampled(bank_cmd.flush_req)),
                         32'($sampled(m_flush)));

    // Held for exactly the selective-flush wait
    assert property (@(posedge clk) disable iff (!rst_n)
        bank_cmd.sel_flush_req == (pend && pend_kind == OP_SEL_FLUSH))
    else report_mismatch("sel_flush_req", 32'($sampled(bank_cmd.sel_flush_req)),
                         32'($sampled(pend) && $sampled(pend_kind) == OP_SEL_FLUSH));

    assert property (@(posedge clk) disable iff (!rst_n) bank_cmd.sel_flush_addr == m_sel_addr)
    else report_mismatch("sel_flush_addr", $sampled(bank_cmd.sel_flush_addr),
                         $sampled(m_sel_addr));

    initial
    begin
        #(TIMEOUT_NS);
        $display("Watchdog expired at %0t, the test sequence did not finish", $time);
        $display("Regression failed");
        $finish;
    end

    initial
    begin
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset_state");
        read_reg(`ICM_OFS_ENABLE);
        finish_test();

        start_test("enable_disable");
        write_reg(`ICM_OFS_ENABLE, 32'd1);
        read_reg(`ICM_OFS_ENABLE);
        write_reg(`ICM_OFS_ENABLE, 32'd0);
        read_reg(`ICM_OFS_ENABLE);
        finish_test();

        start_test("full_flush");
        write_reg(`ICM_OFS_FLUSH, 32'd1);
        read_reg(`ICM_OFS_FLUSH);   // Self cleared by now
        finish_test();

        start_test("selective_flush");
        sel_addr = $random(seed);
        write_reg(`ICM_OFS_SEL_FLUSH, sel_addr);
        read_reg(`ICM_OFS_SEL_FLUSH);
        finish_test();

        start_test("bus_rules");
        read_reg(8'h0C);
        write_reg(8'h10, 32'h1234_5678);
        finish_test();

        repeat (2) @(posedge clk);
        $display("Tests: %0d ok, %0d failed, %0d check errors", tests_ok, tests_bad, errors);
        if (tests_bad == 0 && errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- verilog/icache_maint_top.sv
/*
 * I-cache maintenance controller top level
 * Register block, maintenance FSM and response stage
 */

`timescale 1ns/1ps

`include "icache_maint_defs.svh"

module icache_maint_top
(
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  periph_bus_pkg::periph_req_t  req_i,
    output logic                         gnt_o,
    output periph_bus_pkg::periph_rsp_t  rsp_o,
    output icache_maint_pkg::bank_cmd_t  bank_cmd_o,
    input  icache_maint_pkg::bank_ack_t  bank_ack_i
);

    icache_maint_pkg::bank_cmd_t  regs_cmd;
    logic [`ICM_DATA_W-1:0]       rdata;
    logic                         wr_en;
    logic                         flush_done;
    logic                         sel_flush_req;
    logic                         respond;
    logic                         accept;

    assign accept = req_i.req & gnt_o;   // Handshake completes this cycle

    always_comb
    begin
        bank_cmd_o               = regs_cmd;
        bank_cmd_o.sel_flush_req = sel_flush_req;
    end

    icache_maint_regs i_regs (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .req_i        ( req_i      ),
        .wr_en_i      ( wr_en      ),
        .flush_done_i ( flush_done ),
        .rdata_o      ( rdata      ),
        .cmd_o        ( regs_cmd   )
    );

    icache_maint_fsm i_fsm (
        .clk_i           ( clk_i         ),
        .rst_ni          ( rst_ni        ),
        .req_i           ( req_i         ),
        .ack_i           ( bank_ack_i    ),
        .gnt_o           ( gnt_o         ),
        .wr_en_o         ( wr_en         ),
        .flush_done_o    ( flush_done    ),
        .sel_flush_req_o ( sel_flush_req ),
        .respond_o       ( respond       )
    );

    periph_resp_stage i_resp (
        .clk_i     ( clk_i   ),
        .rst_ni    ( rst_ni  ),
        .req_i     ( req_i   ),
        .accept_i  ( accept  ),
        .respond_i ( respond ),
        .rdata_i   ( rdata   ),
        .rsp_o     ( rsp_o   )
    );

endmodule

//--- verilog/periph_resp_stage.sv
/*
 * Registered response stage of the peripheral bus
 * Keeps the id of the accepted request and returns it with
 * the read data one cycle after the respond strobe
 */

`timescale 1ns/1ps

`include "icache_maint_defs.svh"

module periph_resp_stage
(
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  periph_bus_pkg::periph_req_t  req_i,
    input  logic                         accept_i,
    input  logic                         respond_i,
    input  logic [`ICM_DATA_W-1:0]       rdata_i,
    output periph_bus_pkg::periph_rsp_t  rsp_o
);

    logic [`ICM_ID_W-1:0]    id_q;   // Id of the transaction in flight
    logic                    valid_q;
    logic [`ICM_ID_W-1:0]    rsp_id_q;
    logic [`ICM_DATA_W-1:0]  rdata_q;

    always_ff @(posedge clk_i, negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            valid_q  <= 1'b0;
            id_q     <= '0;
            rsp_id_q <= '0;
            rdata_q  <= '0;
        end
        else
        begin
            valid_q <= respond_i;
            if (accept_i)
                id_q <= req_i.id;
            if (respond_i)
            begin
                // Reads respond in their accept cycle, so take the live id
                rsp_id_q <= accept_i ? req_i.id : id_q;
                rdata_q  <= rdata_i;
            end
        end
    end

    always_comb
    begin
        rsp_o       = '0;   // Opcode bit stays zero
        rsp_o.valid = valid_q;
        rsp_o.id    = rsp_id_q;
        rsp_o.rdata = rdata_q;
    end

    // Exactly one valid cycle per response
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_o.valid |=> !rsp_o.valid)
    else $error("response valid held for two cycles");

endmodule

//--- verilog/icache_maint_fsm.sv
/*
 * Maintenance FSM
 * Grants bus requests in idle, starts register writes and waits
 * for the bank acknowledges before pulsing the respond strobe
 */

`timescale 1ns/1ps

module icache_maint_fsm
(
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  periph_bus_pkg::periph_req_t  req_i,
    input  icache_maint_pkg::bank_ack_t  ack_i,
    output logic                         gnt_o,
    output logic                         wr_en_o,
    output logic                         flush_done_o,
    output logic                         sel_flush_req_o,
    output logic                         respond_o
);

    icache_maint_pkg::maint_state_e  state_q;
    icache_maint_pkg::maint_state_e  state_d;
    icache_maint_pkg::reg_sel_e      reg_sel;

    assign reg_sel = icache_maint_pkg::decode_reg(req_i.addr);

    // Only idle accepts a new transaction
    assign gnt_o = (state_q == icache_maint_pkg::ST_IDLE);

    always_comb
    begin
        state_d         = state_q;
        wr_en_o         = 1'b0;
        flush_done_o    = 1'b0;
        sel_flush_req_o = 1'b0;
        respond_o       = 1'b0;

        case (state_q)
            icache_maint_pkg::ST_IDLE:
            begin
                if (req_i.req && req_i.wen)
                begin
                    respond_o = 1'b1;   // Reads answer right away
                end
                else if (req_i.req)
                begin
                    wr_en_o = 1'b1;
                    case (reg_sel)
                        icache_maint_pkg::REG_ENABLE:
                        begin
                            // Bit 0 is the enable flag
                            if (req_i.wdata[0] == 1'b0)
                                state_d = icache_maint_pkg::ST_WAIT_DISABLE;
                            else
                                state_d = icache_maint_pkg::ST_WAIT_ENABLE;
                        end
                        icache_maint_pkg::REG_FLUSH:
                        begin
                            state_d = icache_maint_pkg::ST_WAIT_FLUSH;
                        end
                        icache_maint_pkg::REG_SEL_FLUSH:
                        begin
                            state_d = icache_maint_pkg::ST_WAIT_SEL_FLUSH;
                        end
                        default:
                        begin
                            respond_o = 1'b1;   // Unmapped write, no bank work
                        end
                    endcase
                end
            end

            icache_maint_pkg::ST_WAIT_ENABLE:
            begin
                if (~|ack_i.bypass_ack)   // Every bank out of bypass
                begin
                    respond_o = 1'b1;
                    state_d   = icache_maint_pkg::ST_IDLE;
                end
            end

            icache_maint_pkg::ST_WAIT_DISABLE:
            begin
                if (&ack_i.bypass_ack)    // Every bank bypassed
                begin
                    respond_o = 1'b1;
                    state_d   = icache_maint_pkg::ST_IDLE;
                end
            end

            icache_maint_pkg::ST_WAIT_FLUSH:
            begin
                if (ack_i.flush_ack)
                begin
                    respond_o    = 1'b1;
                    flush_done_o = 1'b1;
                    state_d      = icache_maint_pkg::ST_IDLE;
                end
            end

            icache_maint_pkg::ST_WAIT_SEL_FLUSH:
            begin
                sel_flush_req_o = 1'b1;   // Held for the whole wait
                if (ack_i.sel_flush_ack)
                begin
                    respond_o = 1'b1;
                    state_d   = icache_maint_pkg::ST_IDLE;
                end
            end

            default:
            begin
                state_d = icache_maint_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i, negedge rst_ni)
    begin
        if (!rst_ni)
            state_q <= icache_maint_pkg::ST_IDLE;
        else
            state_q <= state_d;
    end

    // A mapped write closes the bus for its bank operation
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (req_i.req && gnt_o && !req_i.wen && (reg_sel != icache_maint_pkg::REG_UNMAPPED))
            |=> !gnt_o)
    else $error("grant still given after a bank write was accepted");

    // Bus stays closed until the completing respond strobe
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!gnt_o && !respond_o) |=> !gnt_o)
    else $error("grant returned before the bank operation completed");

endmodule

//--- verilog/icache_maint_regs.sv
/*
 * Register block of the I-cache maintenance controller
 * Holds enable, flush and selective-flush address, decodes writes,
 * clears the flush bit on completion and muxes the read data
 */

`timescale 1ns/1ps

`include "icache_maint_defs.svh"

module icache_maint_regs
(
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  periph_bus_pkg::periph_req_t  req_i,
    input  logic                         wr_en_i,       // Write accepted this cycle
    input  logic                         flush_done_i,  // Flush acknowledged by banks
    output logic [`ICM_DATA_W-1:0]       rdata_o,
    output icache_maint_pkg::bank_cmd_t  cmd_o
);

    icache_maint_pkg::reg_sel_e  reg_sel;

    logic                        enable_q;
    logic                        flush_q;
    logic [`ICM_ADDR_W-1:0]      sel_flush_addr_q;

    assign reg_sel = icache_maint_pkg::decode_reg(req_i.addr);

    // Software visible registers
    always_ff @(posedge clk_i, negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            enable_q         <= 1'b0;   // Banks start bypassed
            flush_q          <= 1'b0;
            sel_flush_addr_q <= '0;
        end
        else if (wr_en_i)
        begin
            case (reg_sel)
                icache_maint_pkg::REG_ENABLE:
                begin
                    enable_q <= req_i.wdata[0];
                end
                icache_maint_pkg::REG_FLUSH:
                begin
                    flush_q <= req_i.wdata[0];
                end
                icache_maint_pkg::REG_SEL_FLUSH:
                begin
                    sel_flush_addr_q <= req_i.wdata;
                end
                default:
                begin
                    // Unmapped write, nothing stored
                end
            endcase
        end
        else if (flush_done_i)
        begin
            flush_q <= 1'b0;   // Self clearing once banks are done
        end
    end

    // Read data, sampled by the response stage
    always_comb
    begin
        case (reg_sel)
            icache_maint_pkg::REG_ENABLE:
            begin
                rdata_o = {{(`ICM_DATA_W-1){1'b0}}, enable_q};
            end
            icache_maint_pkg::REG_FLUSH:
            begin
                rdata_o = {{(`ICM_DATA_W-1){1'b0}}, flush_q};
            end
            icache_maint_pkg::REG_SEL_FLUSH:
            begin
                rdata_o = sel_flush_addr_q;
            end
            default:
            begin
                rdata_o = `ICM_UNMAPPED_RDATA;
            end
        endcase
    end

    // Bank commands driven straight from the registers
    always_comb
    begin
        cmd_o                = '0;
        cmd_o.bypass_req     = ~enable_q;
        cmd_o.flush_req      = flush_q;
        cmd_o.sel_flush_addr = sel_flush_addr_q;
        cmd_o.sel_flush_req  = 1'b0;   // Merged in at top level from the FSM
    end

    // Flush completion only comes from a wait state, never with a new write
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(flush_done_i && wr_en_i))
    else $error("flush_done_i coincides with a register write");

endmodule

//--- verilog/icache_maint_pkg.sv
/*
 * I-cache maintenance types
 *   reg_sel_e, maint_state_e, bank_cmd_t, bank_ack_t
 *   decode_reg  maps a bus address onto a register select
 */

`include "icache_maint_defs.svh"

package icache_maint_pkg;

    typedef enum logic [1:0] {
        REG_ENABLE,
        REG_FLUSH,
        REG_SEL_FLUSH,
        REG_UNMAPPED
    } reg_sel_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_ENABLE,
        ST_WAIT_DISABLE,
        ST_WAIT_FLUSH,
        ST_WAIT_SEL_FLUSH
    } maint_state_e;

    // Commands toward the cache banks
    typedef struct packed {
        logic                      bypass_req;
        logic                      flush_req;
        logic                      sel_flush_req;
        logic [`ICM_ADDR_W-1:0]    sel_flush_addr;
    } bank_cmd_t;

    // Acknowledges from the cache banks
    typedef struct packed {
        logic [`ICM_NB_BYPASS-1:0] bypass_ack;  // All low = enabled, all high = bypassed
        logic                      flush_ack;
        logic                      sel_flush_ack;
    } bank_ack_t;

    // Only the low offset bits take part in the decode
    function automatic reg_sel_e decode_reg(input logic [`ICM_ADDR_W-1:0] addr);
        case (addr[`ICM_OFS_BITS-1:0])
            `ICM_OFS_ENABLE:    return REG_ENABLE;
            `ICM_OFS_FLUSH:     return REG_FLUSH;
            `ICM_OFS_SEL_FLUSH: return REG_SEL_FLUSH;
            default:            return REG_UNMAPPED;
        endcase
    endfunction

endpackage

//--- verilog/periph_bus_pkg.sv
/*
 * Peripheral register bus types
 *   periph_req_t  request from the bus master
 *   periph_rsp_t  response back to the bus master
 */

`include "icache_maint_defs.svh"

package periph_bus_pkg;

    // One request, held by the master until granted
    typedef struct packed {
        logic                      req;
        logic [`ICM_ADDR_W-1:0]    addr;
        logic                      wen;   // Low for write, high for read
        logic [`ICM_DATA_W-1:0]    wdata;
        logic [`ICM_DATA_W/8-1:0]  be;
        logic [`ICM_ID_W-1:0]      id;
    } periph_req_t;

    // One response, valid for a single cycle
    typedef struct packed {
        logic                      valid;
        logic                      opc;   // Error flag, zero here
        logic [`ICM_ID_W-1:0]      id;
        logic [`ICM_DATA_W-1:0]    rdata;
    } periph_rsp_t;

endpackage

//--- verilog/icache_maint_defs.svh
/*
 * Shared constants of the I-cache maintenance controller:
 * bus widths, bypass acknowledge count, register byte offsets
 * and the marker returned on unmapped reads
 */

`ifndef ICACHE_MAINT_DEFS_SVH
`define ICACHE_MAINT_DEFS_SVH

// Peripheral bus widths
`define ICM_ADDR_W 32
`define ICM_DATA_W 32
`define ICM_ID_W   5

// Banks plus one extra acknowledge line
`define ICM_NB_BYPASS 5

// Register byte offsets, decoded on the low address bits
`define ICM_OFS_BITS      8
`define ICM_OFS_ENABLE    8'h00
`define ICM_OFS_FLUSH     8'h04
`define ICM_OFS_SEL_FLUSH 8'h08

// Read data for offsets with no register behind them
`define ICM_UNMAPPED_RDATA 32'hDEAD_CACE

`endif
